// ==== pipeCtrl_params.svh ====
`ifndef PIPECTRL_PARAMS_SVH
`define PIPECTRL_PARAMS_SVH

// Width of an architectural register number
// Sixteen visible registers in user mode give four bits
`define REG_IDX_W 4

// Register number that aliases the program counter
// Reads of this register take the PC value from the datapath
// and therefore never take part in operand forwarding
`define PC_REG 15

// A register tag is a register number plus a use or write flag
// kept next to it in the stage structs of the package
// The ISA fields of the instruction word stay four bits wide
// so this width must not grow past the encoding

`endif

// ==== pipeCtrlPkg.sv ====
`include "pipeCtrl_params.svh"

package pipeCtrlPkg;

  // Instruction class codes taken from bits 27:26
  localparam logic [1:0] classDp = 2'b00;
  localparam logic [1:0] classLs = 2'b01;

  // Data-processing format, Rm sits in the low nibble of op2
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  cls;
    logic        imm;
    logic [3:0]  opcode;
    logic        sBit;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] op2;
  } dpViewT;

  // Single load/store format with P, U, B and W addressing bits
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  cls;
    logic        imm;
    logic        preIdx;
    logic        up;
    logic        byteXfer;
    logic        writeBack;
    logic        load;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset;
  } lsViewT;

  // One fetched word, read through whichever view its class selects
  typedef union packed {
    dpViewT dpView;
    lsViewT lsView;
  } instrWordT;

  // Register usage of one instruction as it moves down the pipe
  typedef struct packed {
    logic                  valid;
    logic [`REG_IDX_W-1:0] src1;
    logic                  src1Use;
    logic [`REG_IDX_W-1:0] src2;
    logic                  src2Use;
    logic [`REG_IDX_W-1:0] dest;
    logic                  regWrite;
    logic                  memToReg;
  } regTagsT;

  // Source-to-destination hits between stages
  typedef struct packed {
    logic match1EM;
    logic match1EW;
    logic match2EM;
    logic match2EW;
    logic match1DE;
    logic match2DE;
  } matchT;

  // Exception requests, listed from highest to lowest priority
  typedef struct packed {
    logic prefetchAbortE;
    logic dataAbort;
    logic irq;
    logic fiq;
    logic undefinedE;
    logic swiE;
  } exceptT;

  // Side levels from the caches, branch unit and CPSR logic
  typedef struct packed {
    logic dStall;
    logic iStall;
    logic branchTakenE;
    logic pcSrcW;
    logic pcWrPendingF;
    logic regToCpsr;
    logic cpsrToReg;
    logic cpsrEMW;
  } sideInT;

  // Stall and flush levels per stage
  typedef struct packed {
    logic stallF;
    logic stallD;
    logic stallE;
    logic stallM;
    logic stallW;
    logic flushD;
    logic flushE;
    logic flushM;
    logic flushW;
  } stallFlushT;

  // Operand source for an Execute-stage read port
  typedef enum logic [1:0] {
    fwdNone  = 2'd0,
    fwdFromW = 2'd1,
    fwdFromM = 2'd2
  } fwdSelT;

  // Offset added to the saved PC when an exception is taken
  typedef enum logic [1:0] {
    pcPlus0 = 2'd0,
    pcPlus4 = 2'd1,
    pcPlus8 = 2'd2
  } pcInSelT;

endpackage

// ==== regFieldDecode.sv ====
`timescale 1ns/1ps

module regFieldDecode (
  input  pipeCtrlPkg::instrWordT instrD,
  input  logic                   validD,
  output pipeCtrlPkg::regTagsT   tagsD
);

  import pipeCtrlPkg::*;

  // Class bits sit at the same place in both views
  logic [1:0] instrClass;

  // Test and compare opcodes 1000 to 1011 only set flags
  logic isCompare;

  assign instrClass = instrD.dpView.cls;
  assign isCompare  = (instrD.dpView.opcode[3:2] == 2'b10);

  always_comb begin
    // Start from an empty tag so unused fields stay zero
    tagsD       = '0;
    tagsD.valid = validD;
    if (validD) begin
      case (instrClass)
        classDp: begin
          // Rn is always read by the data-processing format
          tagsD.src1    = instrD.dpView.rn;
          tagsD.src1Use = 1'b1;
          tagsD.dest    = instrD.dpView.rd;
          // Register operand 2 reads Rm from the low nibble
          if (!instrD.dpView.imm) begin
            tagsD.src2    = instrD.dpView.op2[3:0];
            tagsD.src2Use = 1'b1;
          end
          tagsD.regWrite = !isCompare;
        end
        classLs: begin
          // Base register is read for address generation
          tagsD.src1    = instrD.lsView.rn;
          tagsD.src1Use = 1'b1;
          if (instrD.lsView.load) begin
            // Loaded data reaches the register file late
            tagsD.dest     = instrD.lsView.rd;
            tagsD.regWrite = 1'b1;
            tagsD.memToReg = 1'b1;
          end else begin
            // A store reads Rd as its data operand
            tagsD.src2    = instrD.lsView.rd;
            tagsD.src2Use = 1'b1;
          end
        end
        default: begin
          // Branch and coprocessor classes carry no register tags here
        end
      endcase
    end
  end

endmodule

// ==== stageTagPipe.sv ====
`timescale 1ns/1ps

module stageTagPipe (
  input  logic                    clk,
  input  logic                    rst,
  input  pipeCtrlPkg::regTagsT    tagsD,
  input  pipeCtrlPkg::stallFlushT sf,
  output pipeCtrlPkg::regTagsT    tagsE,
  output pipeCtrlPkg::regTagsT    tagsM,
  output pipeCtrlPkg::regTagsT    tagsW
);

  import pipeCtrlPkg::*;

  // Next value of one stage register
  // A flush empties the stage even when a load would happen
  // A stall keeps the current contents
  function automatic regTagsT nextStage(
    input regTagsT cur,
    input regTagsT incoming,
    input logic    stall,
    input logic    flush
  );
    regTagsT nxt;
    if (flush) begin
      nxt = '0;
    end else if (stall) begin
      nxt = cur;
    end else begin
      nxt = incoming;
    end
    return nxt;
  endfunction

  // Combinational next state for all three stages
  regTagsT nextE;
  regTagsT nextM;
  regTagsT nextW;

  always_comb begin
    nextE = nextStage(tagsE, tagsD, sf.stallE, sf.flushE);
    nextM = nextStage(tagsM, tagsE, sf.stallM, sf.flushM);
    // Under back-pressure W is both held and flushed
    // so the held instruction is not written back twice
    nextW = nextStage(tagsW, tagsM, sf.stallW, sf.flushW);
  end

  // Execute stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      tagsE <= '0;
    end else begin
      tagsE <= nextE;
    end
  end

  // Memory stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      tagsM <= '0;
    end else begin
      tagsM <= nextM;
    end
  end

  // Writeback stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      tagsW <= '0;
    end else begin
      tagsW <= nextW;
    end
  end

  // Each stage updates on its own controls, so a bubble can open
  // in E while M and W keep moving

endmodule

// ==== regMatch.sv ====
`timescale 1ns/1ps
`include "pipeCtrl_params.svh"

module regMatch (
  input  pipeCtrlPkg::regTagsT tagsD,
  input  pipeCtrlPkg::regTagsT tagsE,
  input  pipeCtrlPkg::regTagsT tagsM,
  input  pipeCtrlPkg::regTagsT tagsW,
  output pipeCtrlPkg::matchT   match
);

  import pipeCtrlPkg::*;

  // True when a read source hits the destination of a later stage
  // The PC is never forwarded since its value comes from the datapath
  function automatic logic srcHits(
    input logic                  srcUse,
    input logic [`REG_IDX_W-1:0] src,
    input regTagsT               later
  );
    logic notPc;
    notPc = (src != `REG_IDX_W'(`PC_REG));
    return srcUse && notPc && later.valid && (src == later.dest);
  endfunction

  always_comb begin
    // Execute sources against Memory and Writeback for forwarding
    match.match1EM = srcHits(tagsE.src1Use, tagsE.src1, tagsM);
    match.match1EW = srcHits(tagsE.src1Use, tagsE.src1, tagsW);
    match.match2EM = srcHits(tagsE.src2Use, tagsE.src2, tagsM);
    match.match2EW = srcHits(tagsE.src2Use, tagsE.src2, tagsW);
    // Decode sources against Execute for the load-use check
    match.match1DE = srcHits(tagsD.src1Use, tagsD.src1, tagsE);
    match.match2DE = srcHits(tagsD.src2Use, tagsD.src2, tagsE);
  end

  // Whether a hit matters is decided in the hazard unit, which
  // knows the write and load flags of the later stage

endmodule

// ==== hazard.sv ====
`timescale 1ns/1ps

module hazard (
  // Clock and reset serve the bound checker only
  input  logic                    clk,
  input  logic                    rst,
  input  pipeCtrlPkg::matchT      match,
  input  logic                    regWriteM,
  input  logic                    regWriteW,
  input  logic                    memToRegE,
  input  pipeCtrlPkg::sideInT     side,
  input  pipeCtrlPkg::exceptT     exc,
  output pipeCtrlPkg::fwdSelT     forwardAE,
  output pipeCtrlPkg::fwdSelT     forwardBE,
  output pipeCtrlPkg::stallFlushT sf,
  output logic                    exceptionSavePC,
  output pipeCtrlPkg::pcInSelT    pcInSelect
);

  import pipeCtrlPkg::*;

  // Load result not yet available for the instruction in Decode
  logic ldrStallD;

  // Either cache is holding the pipeline
  logic backPressure;

  // Memory stage is the younger producer and wins over Writeback
  function automatic fwdSelT pickFwd(
    input logic hitM,
    input logic hitW,
    input logic wrM,
    input logic wrW
  );
    fwdSelT sel;
    if (hitM && wrM) begin
      sel = fwdFromM;
    end else if (hitW && wrW) begin
      sel = fwdFromW;
    end else begin
      sel = fwdNone;
    end
    return sel;
  endfunction

  // Operand forwarding for both Execute read ports
  always_comb begin
    forwardAE = pickFwd(match.match1EM, match.match1EW, regWriteM, regWriteW);
    forwardBE = pickFwd(match.match2EM, match.match2EW, regWriteM, regWriteW);
  end

  assign ldrStallD    = (match.match1DE | match.match2DE) & memToRegE;
  assign backPressure = side.dStall | side.iStall;

  // Any exception request saves the PC of the faulting stage
  assign exceptionSavePC = |exc;

  always_comb begin
    // Decode waits for a load result or for the caches
    sf.stallD = ldrStallD | backPressure;
    // Fetch also waits on a pending PC write or a CPSR move
    sf.stallF = sf.stallD | side.pcWrPendingF | side.regToCpsr | side.cpsrToReg;

    // Back-pressure freezes every later stage together
    sf.stallE = backPressure;
    sf.stallM = backPressure;
    sf.stallW = backPressure;

    // The frozen W instruction must not write back again
    sf.flushW = backPressure;

    // Bubble into E on load-use, taken branch or a CPSR move in flight
    // but never while E is frozen, or the held instruction would be lost
    sf.flushE = (ldrStallD | side.branchTakenE | side.cpsrEMW) & ~sf.stallE;

    // Drop the instruction in Decode whenever fetch went the wrong way
    sf.flushD = side.pcWrPendingF | side.pcSrcW | side.branchTakenE |
                side.iStall | side.regToCpsr | side.cpsrToReg;

    // Exceptions squash the instruction leaving Execute
    sf.flushM = exceptionSavePC & ~sf.stallM;
  end

  // Return-address offset for the highest-priority exception
  always_comb begin
    if (exc.prefetchAbortE) begin
      pcInSelect = pcPlus0;
    end else if (exc.dataAbort) begin
      pcInSelect = pcPlus8;
    end else if (exc.irq) begin
      pcInSelect = pcPlus0;
    end else if (exc.fiq) begin
      pcInSelect = pcPlus0;
    end else if (exc.undefinedE) begin
      pcInSelect = pcPlus4;
    end else if (exc.swiE) begin
      // SWI saves the link one stage late through the pipe
      pcInSelect = pcPlus8;
    end else begin
      pcInSelect = pcPlus0;
    end
  end

endmodule

// ==== pipeCtrlTop.sv ====
`timescale 1ns/1ps

module pipeCtrlTop (
  input  logic                    clk,
  input  logic                    rst,
  input  pipeCtrlPkg::instrWordT  instrD,
  input  logic                    validD,
  input  pipeCtrlPkg::sideInT     side,
  input  pipeCtrlPkg::exceptT     exc,
  output pipeCtrlPkg::fwdSelT     forwardAE,
  output pipeCtrlPkg::fwdSelT     forwardBE,
  output pipeCtrlPkg::stallFlushT sf,
  output logic                    exceptionSavePC,
  output pipeCtrlPkg::pcInSelT    pcInSelect
);

  import pipeCtrlPkg::*;

  // Register tags of the instruction in each stage
  regTagsT tagsD;
  regTagsT tagsE;
  regTagsT tagsM;
  regTagsT tagsW;

  // Hits between Decode, Execute and the later stages
  matchT match;

  regFieldDecode i_decode (
    .instrD (instrD),
    .validD (validD),
    .tagsD  (tagsD)
  );

  // The stall and flush levels from the hazard unit steer the tag pipe
  stageTagPipe i_tagPipe (
    .clk   (clk),
    .rst   (rst),
    .tagsD (tagsD),
    .sf    (sf),
    .tagsE (tagsE),
    .tagsM (tagsM),
    .tagsW (tagsW)
  );

  regMatch i_match (
    .tagsD (tagsD),
    .tagsE (tagsE),
    .tagsM (tagsM),
    .tagsW (tagsW),
    .match (match)
  );

  hazard i_hazard (
    .clk             (clk),
    .rst             (rst),
    .match           (match),
    .regWriteM       (tagsM.regWrite),
    .regWriteW       (tagsW.regWrite),
    .memToRegE       (tagsE.memToReg),
    .side            (side),
    .exc             (exc),
    .forwardAE       (forwardAE),
    .forwardBE       (forwardBE),
    .sf              (sf),
    .exceptionSavePC (exceptionSavePC),
    .pcInSelect      (pcInSelect)
  );

endmodule

// ==== pipeCtrl_asserts.sv ====
`timescale 1ns/1ps

module pipeCtrlAsserts (
  input logic                    clk,
  input logic                    rst,
  input pipeCtrlPkg::matchT      match,
  input logic                    memToRegE,
  input pipeCtrlPkg::sideInT     side,
  input pipeCtrlPkg::stallFlushT sf
);

  import pipeCtrlPkg::*;

  // Number of failed properties, read by the testbench at the end
  int failCount;

  // Causes that may legally hold the pipeline
  logic loadUse;
  logic backPressure;

  initial failCount = 0;

  assign loadUse      = (match.match1DE | match.match2DE) & memToRegE;
  assign backPressure = side.dStall | side.iStall;

  // E and M never hold and empty themselves in the same cycle
  // D under iStall and W under back-pressure raise both on purpose
  noStallFlushE: assert property (@(posedge clk) disable iff (rst)
    !(sf.stallE && sf.flushE))
    else begin
      failCount = failCount + 1;
      $error("Execute stage stalled and flushed in the same cycle");
    end

  noStallFlushM: assert property (@(posedge clk) disable iff (rst)
    !(sf.stallM && sf.flushM))
    else begin
      failCount = failCount + 1;
      $error("Memory stage stalled and flushed in the same cycle");
    end

  // The frozen W instruction is cleared exactly while it is held
  flushWFollowsStallW: assert property (@(posedge clk) disable iff (rst)
    sf.flushW == sf.stallW)
    else begin
      failCount = failCount + 1;
      $error("flushW differs from stallW");
    end

  // Every stall level must trace back to one of its causes
  stallDHasCause: assert property (@(posedge clk) disable iff (rst)
    sf.stallD |-> (loadUse || backPressure))
    else begin
      failCount = failCount + 1;
      $error("stallD raised without load-use or cache stall");
    end

  stallFHasCause: assert property (@(posedge clk) disable iff (rst)
    sf.stallF |-> (sf.stallD || side.pcWrPendingF || side.regToCpsr || side.cpsrToReg))
    else begin
      failCount = failCount + 1;
      $error("stallF raised without a cause");
    end

  lateStallHasCause: assert property (@(posedge clk) disable iff (rst)
    (sf.stallE || sf.stallM || sf.stallW) |-> backPressure)
    else begin
      failCount = failCount + 1;
      $error("Execute, Memory or Writeback stalled without a cache stall");
    end

endmodule

bind hazard pipeCtrlAsserts i_asserts (
  .clk       (clk),
  .rst       (rst),
  .match     (match),
  .memToRegE (memToRegE),
  .side      (side),
  .sf        (sf)
);

// ==== pipeCtrlClkGen.sv ====
`timescale 1ns/1ps

module pipeCtrlClkGen #(
  parameter int periodNs    = 8,
  parameter int resetCycles = 3
) (
  output logic clk,
  output logic rst
);

  // Free-running clock, low for the first half period
  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  // Reset is seen high on the first few rising edges, then released
  // on an edge so that it behaves as a synchronous level
  initial begin
    rst = 1'b1;
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== pipeCtrlTb.sv ====
`timescale 1ns/1ps

module pipeCtrlTb;

  import pipeCtrlPkg::*;

  localparam int clkPeriod    = 8;
  localparam int resetCycles  = 3;
  localparam int marginCycles = 40;

  // Data-processing opcodes used by the stimulus
  localparam logic [3:0] opAdd = 4'b0100;
  localparam logic [3:0] opCmp = 4'b1010;

  // Single side levels, combined with OR where a row needs several
  localparam sideInT sideNone     = '0;
  localparam sideInT sideDStall   = '{dStall: 1'b1, default: 1'b0};
  localparam sideInT sideIStall   = '{iStall: 1'b1, default: 1'b0};
  localparam sideInT sideBranch   = '{branchTakenE: 1'b1, default: 1'b0};
  localparam sideInT sidePcSrcW   = '{pcSrcW: 1'b1, default: 1'b0};
  localparam sideInT sidePcWrPend = '{pcWrPendingF: 1'b1, default: 1'b0};
  localparam sideInT sideRegToCp  = '{regToCpsr: 1'b1, default: 1'b0};
  localparam sideInT sideCpToReg  = '{cpsrToReg: 1'b1, default: 1'b0};
  localparam sideInT sideCpsrEMW  = '{cpsrEMW: 1'b1, default: 1'b0};

  // Single exception requests
  localparam exceptT excNone = '0;
  localparam exceptT excPabt = '{prefetchAbortE: 1'b1, default: 1'b0};
  localparam exceptT excDabt = '{dataAbort: 1'b1, default: 1'b0};
  localparam exceptT excIrq  = '{irq: 1'b1, default: 1'b0};
  localparam exceptT excFiq  = '{fiq: 1'b1, default: 1'b0};
  localparam exceptT excUnd  = '{undefinedE: 1'b1, default: 1'b0};
  localparam exceptT excSwi  = '{swiE: 1'b1, default: 1'b0};

  // Expected stall and flush patterns
  localparam stallFlushT sfNone   = '0;
  localparam stallFlushT sfStallF = '{stallF: 1'b1, default: 1'b0};
  localparam stallFlushT sfFlushD = '{flushD: 1'b1, default: 1'b0};
  localparam stallFlushT sfFlushE = '{flushE: 1'b1, default: 1'b0};
  localparam stallFlushT sfFlushM = '{flushM: 1'b1, default: 1'b0};
  localparam stallFlushT sfLoadUse = '{stallF: 1'b1, stallD: 1'b1, flushE: 1'b1,
                                      default: 1'b0};
  localparam stallFlushT sfBackPr = '{stallF: 1'b1, stallD: 1'b1, stallE: 1'b1,
                                     stallM: 1'b1, stallW: 1'b1, flushW: 1'b1,
                                     default: 1'b0};

  // One table row: inputs for a cycle and the outputs expected in it
  typedef struct packed {
    instrWordT  instr;
    logic       valid;
    sideInT     side;
    exceptT     exc;
    fwdSelT     expA;
    fwdSelT     expB;
    stallFlushT expSf;
    logic       expSave;
    pcInSelT    expPc;
  } rowT;

  logic       clk;
  logic       rst;
  instrWordT  instrD;
  logic       validD;
  sideInT     side;
  exceptT     exc;
  fwdSelT     forwardAE;
  fwdSelT     forwardBE;
  stallFlushT sf;
  logic       exceptionSavePC;
  pcInSelT    pcInSelect;

  rowT         rows[$];
  logic [31:0] lcgState;
  int          errorCount;
  int          rowsChecked;
  logic        tableBuilt;

  pipeCtrlClkGen #(.periodNs(clkPeriod), .resetCycles(resetCycles)) i_clkGen (
    .clk (clk),
    .rst (rst)
  );

  pipeCtrlTop i_dut (
    .clk             (clk),
    .rst             (rst),
    .instrD          (instrD),
    .validD          (validD),
    .side            (side),
    .exc             (exc),
    .forwardAE       (forwardAE),
    .forwardBE       (forwardBE),
    .sf              (sf),
    .exceptionSavePC (exceptionSavePC),
    .pcInSelect      (pcInSelect)
  );

  // Numerical Recipes constants for a full-period 32-bit LCG
  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Always-executed data-processing word, immediate operand 2 hides Rm
  function automatic instrWordT dpWord(
    input logic [3:0] opcode,
    input logic       imm,
    input logic [3:0] rn,
    input logic [3:0] rd,
    input logic [3:0] rm
  );
    instrWordT w;
    w               = '0;
    w.dpView.cond   = 4'hE;
    w.dpView.cls    = 2'b00;
    w.dpView.imm    = imm;
    w.dpView.opcode = opcode;
    w.dpView.sBit   = (opcode == opCmp);
    w.dpView.rn     = rn;
    w.dpView.rd     = rd;
    w.dpView.op2    = imm ? 12'h0FF : {8'h00, rm};
    return w;
  endfunction

  // Pre-indexed word transfer with a small positive offset
  function automatic instrWordT lsWord(
    input logic       load,
    input logic [3:0] rn,
    input logic [3:0] rd
  );
    instrWordT w;
    w               = '0;
    w.lsView.cond   = 4'hE;
    w.lsView.cls    = 2'b01;
    w.lsView.preIdx = 1'b1;
    w.lsView.up     = 1'b1;
    w.lsView.load   = load;
    w.lsView.rn     = rn;
    w.lsView.rd     = rd;
    w.lsView.offset = 12'h004;
    return w;
  endfunction

  // Branch or coprocessor class word with random register fields
  function automatic instrWordT fillerWord(input logic [31:0] rnd);
    instrWordT w;
    w            = rnd;
    w.dpView.cls = {1'b1, rnd[0]};
    return w;
  endfunction

  task automatic addRow(
    input instrWordT  w,
    input logic       v,
    input sideInT     sIn,
    input exceptT     eIn,
    input fwdSelT     a,
    input fwdSelT     b,
    input stallFlushT s,
    input logic       save,
    input pcInSelT    pc
  );
    rowT r;
    r.instr   = w;
    r.valid   = v;
    r.side    = sIn;
    r.exc     = eIn;
    r.expA    = a;
    r.expB    = b;
    r.expSf   = s;
    r.expSave = save;
    r.expPc   = pc;
    rows.push_back(r);
  endtask

  task automatic addInstr(input instrWordT w, input fwdSelT a, input fwdSelT b,
                          input stallFlushT s);
    addRow(w, 1'b1, sideNone, excNone, a, b, s, 1'b0, pcPlus0);
  endtask

  // Empty Decode slot with the given side levels
  task automatic addIdle(input sideInT sIn, input fwdSelT a, input fwdSelT b,
                         input stallFlushT s);
    addRow('0, 1'b0, sIn, excNone, a, b, s, 1'b0, pcPlus0);
  endtask

  task automatic addQuiet();
    addIdle(sideNone, fwdNone, fwdNone, sfNone);
  endtask

  // Exception request on an empty Decode slot, the PC is always saved
  task automatic addExc(input exceptT eIn, input sideInT sIn, input stallFlushT s,
                        input pcInSelT pc);
    addRow('0, 1'b0, sIn, eIn, fwdNone, fwdNone, s, 1'b1, pc);
  endtask

  task automatic addFiller(input int n);
    for (int k = 0; k < n; k++) begin
      lcgState = lcgNext(lcgState);
      addRow(fillerWord(lcgState), 1'b1, sideNone, excNone, fwdNone, fwdNone,
             sfNone, 1'b0, pcPlus0);
    end
  endtask

  // Row k sees row k-1 in E, k-2 in M and k-3 in W unless stalled
  task automatic buildTable();
    // Quiet pipe right after reset
    repeat (4) addQuiet();
    addFiller(8);

    // Two writers of r3 back to back, the younger one in M wins
    addInstr(dpWord(opAdd, 1'b0, 4'd1, 4'd3, 4'd2), fwdNone, fwdNone, sfNone);
    addInstr(dpWord(opAdd, 1'b0, 4'd4, 4'd3, 4'd5), fwdNone, fwdNone, sfNone);
    addInstr(dpWord(opAdd, 1'b0, 4'd3, 4'd6, 4'd3), fwdNone, fwdNone, sfNone);
    addIdle(sideNone, fwdFromM, fwdFromM, sfNone);
    // Writer of r8 read two slots later comes from W
    addInstr(dpWord(opAdd, 1'b1, 4'd12, 4'd8, 4'd0), fwdNone, fwdNone, sfNone);
    addQuiet();
    addInstr(dpWord(opAdd, 1'b0, 4'd8, 4'd9, 4'd8), fwdNone, fwdNone, sfNone);
    // Compare names r11 but never writes it
    addInstr(dpWord(opCmp, 1'b0, 4'd10, 4'd11, 4'd10), fwdFromW, fwdFromW, sfNone);
    addInstr(dpWord(opAdd, 1'b0, 4'd11, 4'd1, 4'd11), fwdNone, fwdNone, sfNone);
    addQuiet();
    // Writes to the PC are never forwarded
    addInstr(dpWord(opAdd, 1'b1, 4'd12, 4'd15, 4'd0), fwdNone, fwdNone, sfNone);
    addInstr(dpWord(opAdd, 1'b0, 4'd15, 4'd2, 4'd15), fwdNone, fwdNone, sfNone);
    addQuiet();
    addQuiet();

    // Load to r5 then a reader of r5 through Rn
    addInstr(lsWord(1'b1, 4'd12, 4'd5), fwdNone, fwdNone, sfNone);
    addInstr(dpWord(opAdd, 1'b1, 4'd5, 4'd6, 4'd0), fwdNone, fwdNone, sfLoadUse);
    addInstr(dpWord(opAdd, 1'b1, 4'd5, 4'd6, 4'd0), fwdNone, fwdNone, sfNone);
    addIdle(sideNone, fwdFromW, fwdNone, sfNone);
    // Same hazard through the store data register
    addInstr(lsWord(1'b1, 4'd12, 4'd5), fwdNone, fwdNone, sfNone);
    addInstr(lsWord(1'b0, 4'd13, 4'd5), fwdNone, fwdNone, sfLoadUse);
    addInstr(lsWord(1'b0, 4'd13, 4'd5), fwdNone, fwdNone, sfNone);
    addIdle(sideNone, fwdNone, fwdFromW, sfNone);
    addQuiet();

    // Control-flow and CPSR side levels
    addIdle(sideBranch, fwdNone, fwdNone, sfFlushD | sfFlushE);
    addIdle(sidePcSrcW, fwdNone, fwdNone, sfFlushD);
    addIdle(sideRegToCp, fwdNone, fwdNone, sfStallF | sfFlushD);
    addIdle(sideCpsrEMW, fwdNone, fwdNone, sfFlushE);
    addIdle(sideCpToReg, fwdNone, fwdNone, sfStallF | sfFlushD);
    addIdle(sidePcWrPend, fwdNone, fwdNone, sfStallF | sfFlushD);
    addIdle(sideBranch | sideCpsrEMW, fwdNone, fwdNone, sfFlushD | sfFlushE);
    addQuiet();

    // Data cache stall with r4 forwarding from M held across it
    addInstr(dpWord(opAdd, 1'b1, 4'd12, 4'd4, 4'd0), fwdNone, fwdNone, sfNone);
    addInstr(dpWord(opAdd, 1'b0, 4'd4, 4'd7, 4'd4), fwdNone, fwdNone, sfNone);
    repeat (2) addIdle(sideDStall, fwdFromM, fwdFromM, sfBackPr);
    // A taken branch cannot empty the frozen E stage
    addIdle(sideDStall | sideBranch, fwdFromM, fwdFromM, sfBackPr | sfFlushD);
    addIdle(sideDStall, fwdFromM, fwdFromM, sfBackPr);
    addIdle(sideNone, fwdFromM, fwdFromM, sfNone);
    addQuiet();
    // Instruction cache stall also drops Decode
    addIdle(sideIStall, fwdNone, fwdNone, sfBackPr | sfFlushD);
    addQuiet();

    // Single requests, then pairs resolved by priority
    addExc(excPabt, sideNone, sfFlushM, pcPlus0);
    addExc(excDabt, sideNone, sfFlushM, pcPlus8);
    addExc(excIrq, sideNone, sfFlushM, pcPlus0);
    addExc(excFiq, sideNone, sfFlushM, pcPlus0);
    addExc(excUnd, sideNone, sfFlushM, pcPlus4);
    addExc(excSwi, sideNone, sfFlushM, pcPlus8);
    addExc(excPabt | excDabt, sideNone, sfFlushM, pcPlus0);
    addExc(excDabt | excUnd, sideNone, sfFlushM, pcPlus8);
    addExc(excIrq | excSwi, sideNone, sfFlushM, pcPlus0);
    addExc(excUnd | excSwi, sideNone, sfFlushM, pcPlus4);
    addExc(excFiq | excUnd, sideNone, sfFlushM, pcPlus0);
    // A frozen M stage is not flushed by an exception
    addExc(excSwi, sideDStall, sfBackPr, pcPlus8);
    addExc(excDabt, sideDStall, sfBackPr, pcPlus8);
    addQuiet();
    addFiller(8);
  endtask

  function automatic int assertFailures();
    return i_dut.i_hazard.i_asserts.failCount;
  endfunction

  task automatic checkRow(input int idx, input rowT r);
    if (forwardAE !== r.expA) begin
      errorCount++;
      $display("Fail row %0d forwardAE got %h expected %h", idx, forwardAE, r.expA);
    end
    if (forwardBE !== r.expB) begin
      errorCount++;
      $display("Fail row %0d forwardBE got %h expected %h", idx, forwardBE, r.expB);
    end
    if (sf !== r.expSf) begin
      errorCount++;
      $display("Fail row %0d sf got %h expected %h", idx, sf, r.expSf);
    end
    if (exceptionSavePC !== r.expSave) begin
      errorCount++;
      $display("Fail row %0d exceptionSavePC got %h expected %h", idx,
               exceptionSavePC, r.expSave);
    end
    if (pcInSelect !== r.expPc) begin
      errorCount++;
      $display("Fail row %0d pcInSelect got %h expected %h", idx, pcInSelect, r.expPc);
    end
  endtask

  task automatic printSummary();
    $display("Rows checked %0d of %0d, value errors %0d, assertion failures %0d",
             rowsChecked, rows.size(), errorCount, assertFailures());
  endtask

  initial begin
    instrD      = '0;
    validD      = 1'b0;
    side        = '0;
    exc         = '0;
    errorCount  = 0;
    rowsChecked = 0;
    tableBuilt  = 1'b0;
    lcgState    = 32'h834c9297;
    buildTable();
    tableBuilt = 1'b1;

    wait (rst === 1'b0);
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      instrD <= rows[i].instr;
      validD <= rows[i].valid;
      side   <= rows[i].side;
      exc    <= rows[i].exc;
      // Outputs are combinational, so sample late in the cycle
      #(clkPeriod - 1);
      checkRow(i, rows[i]);
      rowsChecked++;
    end

    printSummary();
    if (errorCount == 0 && assertFailures() == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog sized from the table length plus reset and a margin
  initial begin
    int limitNs;
    wait (tableBuilt === 1'b1);
    limitNs = (rows.size() + resetCycles + marginCycles) * clkPeriod;
    #(limitNs);
    $display("Timeout, the table did not finish within %0d ns", limitNs);
    printSummary();
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+.
pipeCtrlPkg.sv
regFieldDecode.sv
stageTagPipe.sv
regMatch.sv
hazard.sv
pipeCtrlTop.sv
pipeCtrl_asserts.sv
pipeCtrlClkGen.sv
pipeCtrlTb.sv
